// ==== Bender.yml ====
package:
  name: wisc_cpu

sources:
  - include_dirs:
      - .
    files:
      - wisc_pkg.sv
      - wisc_fetch.sv
      - wisc_regfile.sv
      - wisc_decode.sv
      - wisc_execute.sv
      - wisc_memory.sv
      - wisc_cpu_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_wisc_cpu_top.sv

// ==== tb_wisc_model.svh ====
// ISA reference interpreter with expected retire and store lists, plus instruction encoders
`ifndef TB_WISC_MODEL_SVH
`define TB_WISC_MODEL_SVH

word_t      prog [$];                              // Program image, index is word address
reg_write_t exp_retire [$];                        // Nonzero register writes in order
mem_write_t exp_store [$];
int         model_steps;                           // Sizes the per-run wait

function automatic word_t r_form(opcode_t op, reg_idx_t rd, reg_idx_t rs, reg_idx_t rt);
	return {op, rd, rs, rt};                       // Also LW/SW and shifts
endfunction

function automatic word_t byte_form(opcode_t op, reg_idx_t rd, logic [7:0] imm);
	return {op, rd, imm};                          // LHB and LLB
endfunction

function automatic word_t branch_form(br_cond_t cond, logic [8:0] off);
	return {OP_B, cond, off};
endfunction

function automatic word_t call_form(logic [11:0] off);
	return {OP_CALL, off};
endfunction

function automatic word_t bare_form(opcode_t op);
	return {op, 12'h000};                          // RET and HLT
endfunction

function automatic logic cond_holds(br_cond_t c, flags_t f);
	case (c)
		BR_NEQ:  return !f.z;
		BR_EQ:   return f.z;
		BR_GT:   return !f.z && !f.n;
		BR_LT:   return f.n;
		BR_GTE:  return !f.n;
		BR_LTE:  return f.n || f.z;
		BR_OVFL: return f.v;
		default: return 1'b1;
	endcase
endfunction

// Runs prog from address 0 up to HLT, in program order with no pipeline
task automatic interpret_program();
	word_t    rf [16];
	word_t    dm [256];
	flags_t   fl;
	word_t    pc, ins, a, b, res, addr;
	reg_idx_t rd;
	logic     wr, done;
	exp_retire.delete();
	exp_store.delete();
	for (int i = 0; i < 16; i++) begin
		rf[i] = '0;                                // Regfile cleared by reset
	end
	fl = '0;
	pc = '0;
	done = 1'b0;
	model_steps = 0;
	while (!done && model_steps < 1000) begin
		ins  = prog[pc];
		rd   = ins[11:8];
		a    = rf[ins[7:4]];
		b    = rf[ins[3:0]];
		addr = a + {{12{ins[3]}}, ins[3:0]};        // Base plus signed offset
		wr   = 1'b1;
		pc   = pc + 16'd1;                         // pc now PC+1
		model_steps++;
		case (opcode_t'(ins[15:12]))
			OP_ADD: begin
				res = a + b;
				fl  = '{res == '0, res[15], a[15] == b[15] && res[15] != a[15]};
			end
			OP_SUB: begin
				res = a - b;
				fl  = '{res == '0, res[15], a[15] != b[15] && res[15] != a[15]};
			end
			OP_AND: begin
				res = a & b;
				fl  = '{res == '0, res[15], 1'b0};
			end
			OP_NOR: begin
				res = ~(a | b);
				fl  = '{res == '0, res[15], 1'b0};
			end
			OP_XOR: begin
				res = a ^ b;
				fl  = '{res == '0, res[15], 1'b0};
			end
			OP_SLL: res = a << ins[3:0];
			OP_SRL: res = a >> ins[3:0];
			OP_SRA: res = $signed(a) >>> ins[3:0];
			OP_LW:  res = dm[addr[7:0]];
			OP_SW: begin
				wr = 1'b0;
				exp_store.push_back('{1'b1, addr, rf[rd]});
				dm[addr[7:0]] = rf[rd];
			end
			OP_LHB: res = {ins[7:0], rf[rd][7:0]};  // Old low byte kept
			OP_LLB: res = {rf[rd][15:8], ins[7:0]}; // Old high byte kept
			OP_B: begin
				wr = 1'b0;
				if (cond_holds(br_cond_t'(ins[11:9]), fl)) begin
					pc = pc + {{7{ins[8]}}, ins[8:0]};
				end
			end
			OP_CALL: begin
				res = pc;                          // Link is PC+1
				rd  = 4'd15;
				pc  = pc + {{4{ins[11]}}, ins[11:0]};
			end
			OP_RET: begin
				wr = 1'b0;
				pc = rf[15];
			end
			default: begin
				wr   = 1'b0;                       // HLT
				done = 1'b1;
			end
		endcase
		if (wr && rd != '0) begin
			rf[rd] = res;
			exp_retire.push_back('{1'b1, rd, res});
		end
	end
endtask

`endif

// ==== tb_wisc_cpu_top.sv ====
// Testbench for the WISC core with loader, event compare tasks, directed and random tests
`timescale 1ns/1ps
`default_nettype none

module tb_wisc_cpu_top;
	import wisc_pkg::*;

	localparam int cycle_limit = 20000; // Six tests, ~64 instr at ~8 cycles each, plus margin

	logic       clk = 1'b0;
	logic       rst;
	logic       start;
	logic       prog_we;
	imem_addr_t prog_addr;
	word_t      prog_data;
	logic       halted;
	reg_write_t retire;
	mem_write_t store;
	int         cycles = 0;
	reg_write_t got_retire [$];                    // Seen on the retire port
	mem_write_t got_store [$];

	`include "tb_wisc_model.svh"

	wisc_cpu_top dut_i (
		.clk       (clk),
		.rst       (rst),
		.start     (start),
		.prog_we   (prog_we),
		.prog_addr (prog_addr),
		.prog_data (prog_data),
		.halted    (halted),
		.retire    (retire),
		.store     (store)
	);

	always #4 clk = ~clk;                          // 8 ns period

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1, "run stopped");
	endtask

	always @(posedge clk) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			stop_with_failure($sformatf("Timeout after %0d cycles", cycles));
		end
	end

	task automatic compare_retire(input reg_write_t got, input reg_write_t exp, input int n);
		if (got !== exp) begin
			stop_with_failure($sformatf("Mismatch at %0t: retire %0d got r%0d=%h, expected r%0d=%h",
				$time, n, got.idx, got.data, exp.idx, exp.data));
		end
	endtask

	task automatic compare_store(input mem_write_t got, input mem_write_t exp, input int n);
		if (got !== exp) begin
			stop_with_failure($sformatf("Mismatch at %0t: store %0d got [%h]=%h, expected [%h]=%h",
				$time, n, got.addr, got.data, exp.addr, exp.data));
		end
	endtask

	task automatic apply_reset();
		@(posedge clk);
		#1;
		rst = 1'b1;
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;
	endtask

	task automatic load_program();
		for (int i = 0; i < prog.size(); i++) begin
			prog_we   = 1'b1;
			prog_addr = imem_addr_t'(i);
			prog_data = prog[i];
			@(posedge clk);
			#1;
		end
		prog_we = 1'b0;
	endtask

	// Reset, load, start, collect until halted, then check against the model
	task automatic run_program(input string name);
		int waited;
		interpret_program();
		apply_reset();
		load_program();
		start = 1'b1;
		@(posedge clk);
		#1;
		start   = 1'b0;
		waited  = 0;
		got_retire.delete();
		got_store.delete();
		while (!halted) begin
			@(negedge clk);                        // Outputs settled mid-cycle
			if (retire.en) begin
				got_retire.push_back(retire);
			end
			if (store.strobe) begin
				got_store.push_back(store);
			end
			waited++;
			if (waited > 8 * model_steps + 64) begin
				stop_with_failure($sformatf("%s: halted never rose", name));
			end
		end
		for (int i = 0; i < got_retire.size() && i < exp_retire.size(); i++) begin
			compare_retire(got_retire[i], exp_retire[i], i);
		end
		for (int i = 0; i < got_store.size() && i < exp_store.size(); i++) begin
			compare_store(got_store[i], exp_store[i], i);
		end
		if (got_retire.size() != exp_retire.size()) begin
			stop_with_failure($sformatf("%s: %0d register writes retired, %0d expected",
				name, got_retire.size(), exp_retire.size()));
		end
		if (got_store.size() != exp_store.size()) begin
			stop_with_failure($sformatf("%s: %0d stores seen, %0d expected",
				name, got_store.size(), exp_store.size()));
		end
		$display("%s ok: %0d retires, %0d stores", name, got_retire.size(), got_store.size());
	endtask

	task automatic alu_ops_check();
		prog.delete();
		prog.push_back(byte_form(OP_LLB, 4'd1, 8'h34));
		prog.push_back(byte_form(OP_LHB, 4'd1, 8'h12));   // R1 = 0x1234
		prog.push_back(byte_form(OP_LLB, 4'd2, 8'hF0));
		prog.push_back(byte_form(OP_LHB, 4'd2, 8'h80));   // R2 = 0x80F0
		for (int op = 0; op < 5; op++) begin
			prog.push_back(r_form(opcode_t'(op), reg_idx_t'(3 + op), 4'd1, 4'd2));
		end
		prog.push_back(r_form(OP_SLL, 4'd8, 4'd1, 4'd4));
		prog.push_back(r_form(OP_SRL, 4'd9, 4'd2, 4'd3));
		prog.push_back(r_form(OP_SRA, 4'd10, 4'd2, 4'd5)); // Negative source
		prog.push_back(r_form(OP_ADD, 4'd0, 4'd1, 4'd2));  // R0 target, no retire
		prog.push_back(byte_form(OP_LLB, 4'd0, 8'h55));
		prog.push_back(bare_form(OP_HLT));
		run_program("alu and byte ops");
	endtask

	task automatic dependency_chain();
		prog.delete();
		prog.push_back(byte_form(OP_LLB, 4'd1, 8'd1));
		prog.push_back(r_form(OP_ADD, 4'd2, 4'd1, 4'd1));  // Each reads the one before
		prog.push_back(r_form(OP_ADD, 4'd3, 4'd2, 4'd1));
		prog.push_back(r_form(OP_SUB, 4'd4, 4'd3, 4'd2));
		prog.push_back(r_form(OP_XOR, 4'd5, 4'd4, 4'd3));
		prog.push_back(r_form(OP_SLL, 4'd6, 4'd5, 4'd2));
		prog.push_back(r_form(OP_ADD, 4'd6, 4'd6, 4'd6));
		prog.push_back(byte_form(OP_LHB, 4'd6, 8'h7F));    // Old R6 still in flight
		prog.push_back(r_form(OP_AND, 4'd7, 4'd6, 4'd5));
		prog.push_back(bare_form(OP_HLT));
		run_program("dependent chain");
	endtask

	task automatic load_store_chain();
		prog.delete();
		prog.push_back(byte_form(OP_LLB, 4'd1, 8'h40));    // Base
		prog.push_back(byte_form(OP_LLB, 4'd2, 8'h5A));
		prog.push_back(byte_form(OP_LHB, 4'd2, 8'hA5));
		prog.push_back(r_form(OP_SW, 4'd2, 4'd1, 4'd0));
		prog.push_back(r_form(OP_SW, 4'd1, 4'd1, 4'hF));   // Offset -1
		prog.push_back(r_form(OP_LW, 4'd3, 4'd1, 4'd0));
		prog.push_back(r_form(OP_LW, 4'd4, 4'd1, 4'hF));
		prog.push_back(r_form(OP_ADD, 4'd5, 4'd3, 4'd4));  // Load use
		prog.push_back(r_form(OP_SW, 4'd5, 4'd1, 4'd2));
		prog.push_back(r_form(OP_LW, 4'd6, 4'd1, 4'd2));
		prog.push_back(r_form(OP_SW, 4'd6, 4'd0, 4'd3));   // R0 base
		prog.push_back(r_form(OP_LW, 4'd7, 4'd0, 4'd3));
		prog.push_back(bare_form(OP_HLT));
		run_program("store and load");
	endtask

	// Flag setting op that makes cond go the wanted way, R1=1 R2=5 R3=0x7000
	function automatic word_t flag_setter(int cond, bit taken);
		int kind;
		case (br_cond_t'(cond))
			BR_NEQ:  kind = taken ? 1 : 0;
			BR_EQ:   kind = taken ? 0 : 1;
			BR_GT:   kind = taken ? 1 : 0;
			BR_LT:   kind = taken ? 2 : 1;
			BR_GTE:  kind = taken ? 0 : 2;
			BR_LTE:  kind = taken ? 2 : 1;
			BR_OVFL: kind = taken ? 3 : 1;
			default: kind = 0;
		endcase
		case (kind)
			0:       return r_form(OP_SUB, 4'd0, 4'd1, 4'd1); // Zero
			1:       return r_form(OP_SUB, 4'd0, 4'd2, 4'd1); // Positive
			2:       return r_form(OP_SUB, 4'd0, 4'd1, 4'd2); // Negative
			default: return r_form(OP_ADD, 4'd0, 4'd3, 4'd3); // Signed overflow
		endcase
	endfunction

	task automatic branch_conditions();
		prog.delete();
		prog.push_back(byte_form(OP_LLB, 4'd1, 8'd1));
		prog.push_back(byte_form(OP_LLB, 4'd2, 8'd5));
		prog.push_back(byte_form(OP_LHB, 4'd3, 8'h70));
		for (int c = 0; c < 8; c++) begin
			for (int t = 1; t >= 0; t--) begin
				if (c != 7 || t == 1) begin          // Unconditional is never not taken
					prog.push_back(flag_setter(c, t[0]));
					prog.push_back(branch_form(br_cond_t'(c), 9'd1));
					prog.push_back(byte_form(OP_LLB, 4'd10, 8'(16 * c + t))); // Skipped if taken
					prog.push_back(byte_form(OP_LLB, 4'd11, 8'(16 * c + t)));
				end
			end
		end
		prog.push_back(bare_form(OP_HLT));
		run_program("branch conditions");
	endtask

	task automatic call_return();
		prog.delete();
		prog.push_back(byte_form(OP_LLB, 4'd1, 8'd3));     // 0
		prog.push_back(call_form(12'd3));                  // 1 to 5
		prog.push_back(r_form(OP_ADD, 4'd2, 4'd1, 4'd1));  // 2 return point
		prog.push_back(bare_form(OP_HLT));                 // 3
		prog.push_back(byte_form(OP_LLB, 4'd9, 8'hBB));    // 4 never runs
		prog.push_back(byte_form(OP_LLB, 4'd4, 8'h11));    // 5 outer body
		prog.push_back(r_form(OP_ADD, 4'd5, 4'd4, 4'd1));  // 6
		prog.push_back(r_form(OP_ADD, 4'd14, 4'd15, 4'd0)); // 7 save link
		prog.push_back(call_form(12'd2));                  // 8 to 11
		prog.push_back(r_form(OP_ADD, 4'd15, 4'd14, 4'd0)); // 9 restore link
		prog.push_back(bare_form(OP_RET));                 // 10 back to 2
		prog.push_back(r_form(OP_XOR, 4'd6, 4'd5, 4'd4));  // 11 inner body
		prog.push_back(bare_form(OP_RET));                 // 12 back to 9
		prog.push_back(bare_form(OP_HLT));                 // 13 guard
		run_program("call and return");
	endtask

	task automatic random_programs();
		int       sel;
		reg_idx_t rd, rs, rt;
		for (int p = 0; p < 20; p++) begin
			prog.delete();
			for (int r = 1; r < 5; r++) begin
				prog.push_back(byte_form(OP_LLB, reg_idx_t'(r), 8'($urandom)));
				prog.push_back(byte_form(OP_LHB, reg_idx_t'(r), 8'($urandom)));
			end
			for (int k = 0; k < 20; k++) begin
				sel = $urandom_range(9, 0);
				rd  = reg_idx_t'($urandom);
				rs  = reg_idx_t'($urandom);
				rt  = reg_idx_t'($urandom);        // Register or shift amount
				if (sel < 8) begin
					prog.push_back(r_form(opcode_t'(sel), rd, rs, rt));
				end else begin
					prog.push_back(byte_form(sel == 8 ? OP_LHB : OP_LLB, rd, {rs, rt}));
				end
			end
			prog.push_back(bare_form(OP_HLT));
			run_program($sformatf("random program %0d", p));
		end
	endtask

	initial begin
		void'($urandom(32'h4106));
		rst       = 1'b1;
		start     = 1'b0;
		prog_we   = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		alu_ops_check();
		dependency_chain();
		load_store_chain();
		branch_conditions();
		call_return();
		random_programs();
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== wisc_cpu_top.f ====
+incdir+.
wisc_pkg.sv
wisc_fetch.sv
wisc_regfile.sv
wisc_decode.sv
wisc_execute.sv
wisc_memory.sv
wisc_cpu_top.sv
tb_wisc_cpu_top.sv

// ==== wisc_cpu_top.sv ====
// Top level of the five-stage WISC core with stage instances and interconnect
`timescale 1ns/1ps
`default_nettype none

module wisc_cpu_top (
	input  wire logic                 clk,
	input  wire logic                 rst,
	input  wire logic                 start,
	input  wire logic                 prog_we,
	input  wire wisc_pkg::imem_addr_t prog_addr,
	input  wire wisc_pkg::word_t      prog_data,
	output logic                      halted,
	output wisc_pkg::reg_write_t      retire,    // MEM/WB write
	output wisc_pkg::mem_write_t      store
);
	import wisc_pkg::*;

	if_id_t   if_id;
	id_ex_t   id_ex;
	ex_mem_t  ex_mem;
	logic     stall, halt_seen;                  // Decode to fetch
	logic     redirect;                          // Also flushes decode
	word_t    redirect_pc;
	reg_idx_t ex_dst, mem_dst;                   // Hazard sources
	logic     ex_we, mem_we;

	wisc_fetch u_fetch (
		.clk         (clk),
		.rst         (rst),
		.start       (start),
		.prog_we     (prog_we),
		.prog_addr   (prog_addr),
		.prog_data   (prog_data),
		.stall       (stall),
		.redirect    (redirect),
		.halt_seen   (halt_seen),
		.redirect_pc (redirect_pc),
		.if_id       (if_id)
	);

	wisc_decode u_decode (
		.clk       (clk),
		.rst       (rst),
		.if_id     (if_id),
		.wb        (retire),                     // Regfile write port
		.flush     (redirect),
		.ex_dst    (ex_dst),
		.mem_dst   (mem_dst),
		.ex_we     (ex_we),
		.mem_we    (mem_we),
		.id_ex     (id_ex),
		.stall     (stall),
		.halt_seen (halt_seen)
	);

	wisc_execute u_execute (
		.clk         (clk),
		.rst         (rst),
		.id_ex       (id_ex),
		.ex_mem      (ex_mem),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.ex_dst      (ex_dst),
		.ex_we       (ex_we)
	);

	wisc_memory u_memory (
		.clk     (clk),
		.rst     (rst),
		.ex_mem  (ex_mem),
		.wb      (retire),
		.store   (store),
		.halted  (halted),
		.mem_dst (mem_dst),
		.mem_we  (mem_we)
	);

endmodule

`default_nettype wire

// ==== wisc_decode.sv ====
// Decode stage with field split, control decode, hazard stall, halt detect and ID/EX register
`timescale 1ns/1ps
`default_nettype none

module wisc_decode (
	input  wire logic                 clk,
	input  wire logic                 rst,
	input  wire wisc_pkg::if_id_t     if_id,
	input  wire wisc_pkg::reg_write_t wb,         // Regfile write
	input  wire logic                 flush,      // Redirect from execute
	input  wire wisc_pkg::reg_idx_t   ex_dst,     // Pending write in execute
	input  wire wisc_pkg::reg_idx_t   mem_dst,    // Pending write in memory
	input  wire logic                 ex_we,
	input  wire logic                 mem_we,
	output wisc_pkg::id_ex_t          id_ex,
	output logic                      stall,
	output logic                      halt_seen
);
	import wisc_pkg::*;

	opcode_t  opcode;
	reg_idx_t rd, rs, rt;                         // Raw fields
	reg_idx_t ra, rb;                             // Read indices
	reg_idx_t dst;
	word_t    da, db, imm;
	alu_op_t  alu_sel;
	logic     is_alu, reads_a, reads_b, writes;

	// Register matches a write not yet in MEM/WB
	function automatic logic pending(input reg_idx_t idx);
		pending = (idx != '0) && ((ex_we && ex_dst == idx) || (mem_we && mem_dst == idx));
	endfunction

	assign opcode = opcode_t'(if_id.instr[15:12]);
	assign rd     = if_id.instr[11:8];
	assign rs     = if_id.instr[7:4];
	assign rt     = if_id.instr[3:0];
	assign is_alu = !if_id.instr[15];              // ADD through SRA

	assign ra  = (opcode == OP_RET) ? 4'd15 : rs;  // RET jumps through R15
	assign rb  = (opcode inside {OP_SW, OP_LHB, OP_LLB}) ? rd : rt;
	assign dst = (opcode == OP_CALL) ? 4'd15 : rd; // Link register

	assign reads_a = is_alu || opcode inside {OP_LW, OP_SW, OP_RET};
	assign reads_b = opcode inside {OP_ADD, OP_SUB, OP_AND, OP_NOR, OP_XOR,
		OP_SW, OP_LHB, OP_LLB};                   // Shifts use rt as amount
	assign writes  = is_alu || opcode inside {OP_LW, OP_LHB, OP_LLB, OP_CALL};

	always_comb begin
		stall = if_id.valid && !flush &&
			((reads_a && pending(ra)) || (reads_b && pending(rb)));
	end
	assign halt_seen = if_id.valid && !flush && opcode == OP_HLT;

	wisc_regfile u_regfile (
		.clk (clk),
		.rst (rst),
		.wr  (wb),
		.ra  (ra),
		.rb  (rb),
		.da  (da),
		.db  (db)
	);

	always_comb begin
		case (opcode)
			OP_SLL, OP_SRL, OP_SRA: imm = {12'b0, rt};                          // Shift amount
			OP_LW, OP_SW:           imm = {{12{if_id.instr[3]}}, if_id.instr[3:0]};
			OP_LHB:                 imm = {if_id.instr[7:0], 8'h00};           // High byte
			OP_LLB:                 imm = {8'h00, if_id.instr[7:0]};           // Low byte
			OP_B:                   imm = {{7{if_id.instr[8]}}, if_id.instr[8:0]};
			OP_CALL:                imm = {{4{if_id.instr[11]}}, if_id.instr[11:0]};
			default:                imm = '0;
		endcase
	end

	// LHB and LLB ride the shift codes with the immediate source selected
	always_comb begin
		case (opcode)
			OP_LHB:  alu_sel = ALU_SLL;
			OP_LLB:  alu_sel = ALU_SRL;
			default: alu_sel = is_alu ? alu_op_t'(if_id.instr[14:12]) : ALU_ADD;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			id_ex.valid <= 1'b0;
		end else begin
			id_ex.valid       <= if_id.valid && !stall && !flush; // Bubble on stall or flush
			id_ex.halt        <= opcode == OP_HLT;
			id_ex.reg_write   <= writes && dst != '0;  // R0 never retires
			id_ex.mem_read    <= opcode == OP_LW;
			id_ex.mem_write   <= opcode == OP_SW;
			id_ex.alu_src_imm <= opcode inside {OP_LW, OP_SW, OP_LHB, OP_LLB};
			id_ex.alu_op      <= alu_sel;
			id_ex.is_branch   <= opcode == OP_B;
			id_ex.is_call     <= opcode == OP_CALL;
			id_ex.is_ret      <= opcode == OP_RET;
			id_ex.br_cond     <= br_cond_t'(if_id.instr[11:9]);
			id_ex.sets_flags  <= opcode inside {OP_ADD, OP_SUB, OP_AND, OP_NOR, OP_XOR};
			id_ex.a           <= da;
			id_ex.b           <= db;
			id_ex.imm         <= imm;
			id_ex.store_data  <= db;                  // SW data is rd
			id_ex.dst         <= dst;
			id_ex.pc          <= if_id.pc;            // CALL link comes from here
		end
	end

endmodule

`default_nettype wire

// ==== wisc_execute.sv ====
// Execute stage with ALU, flag register, branch test, redirect target and EX/MEM register
`timescale 1ns/1ps
`default_nettype none

module wisc_execute (
	input  wire logic             clk,
	input  wire logic             rst,
	input  wire wisc_pkg::id_ex_t id_ex,
	output wisc_pkg::ex_mem_t     ex_mem,
	output logic                  redirect,     // Taken branch, CALL or RET
	output wisc_pkg::word_t       redirect_pc,
	output wisc_pkg::reg_idx_t    ex_dst,       // For decode hazard test
	output logic                  ex_we
);
	import wisc_pkg::*;

	word_t      op_b;                           // Second ALU operand
	word_t      alu_res;
	word_t      result;                         // Value carried to memory
	word_t      pc_next;                        // PC+1
	logic [3:0] shamt;
	logic       alu_v;
	logic       cond_true;
	flags_t     flags;                          // Last flag-setting result

	assign op_b    = id_ex.alu_src_imm ? id_ex.imm : id_ex.b;
	assign shamt   = id_ex.imm[3:0];
	assign pc_next = id_ex.pc + 16'd1;

	always_comb begin
		alu_v = 1'b0;
		case (id_ex.alu_op)
			ALU_ADD: begin
				alu_res = id_ex.a + op_b;
				alu_v   = (id_ex.a[15] == op_b[15]) && (alu_res[15] != id_ex.a[15]);
			end
			ALU_SUB: begin
				alu_res = id_ex.a - op_b;
				alu_v   = (id_ex.a[15] != op_b[15]) && (alu_res[15] != id_ex.a[15]);
			end
			ALU_AND: alu_res = id_ex.a & op_b;
			ALU_NOR: alu_res = ~(id_ex.a | op_b);
			ALU_XOR: alu_res = id_ex.a ^ op_b;
			// Immediate form is LHB, old low byte kept
			ALU_SLL: alu_res = id_ex.alu_src_imm ? {id_ex.imm[15:8], id_ex.b[7:0]}
			                                     : id_ex.a << shamt;
			// Immediate form is LLB, old high byte kept
			ALU_SRL: alu_res = id_ex.alu_src_imm ? {id_ex.b[15:8], id_ex.imm[7:0]}
			                                     : id_ex.a >> shamt;
			ALU_SRA: alu_res = word_t'($signed(id_ex.a) >>> shamt);
			default: alu_res = id_ex.a;
		endcase
	end

	assign result = id_ex.is_call ? pc_next : alu_res; // CALL links PC+1

	always_comb begin
		case (id_ex.br_cond)
			BR_NEQ:  cond_true = !flags.z;
			BR_EQ:   cond_true = flags.z;
			BR_GT:   cond_true = !flags.z && !flags.n;
			BR_LT:   cond_true = flags.n;
			BR_GTE:  cond_true = !flags.n;
			BR_LTE:  cond_true = flags.n || flags.z;
			BR_OVFL: cond_true = flags.v;
			default: cond_true = 1'b1;              // Unconditional
		endcase
	end

	assign redirect = id_ex.valid &&
		((id_ex.is_branch && cond_true) || id_ex.is_call || id_ex.is_ret);
	assign redirect_pc = id_ex.is_ret ? id_ex.a : pc_next + id_ex.imm;

	assign ex_dst = id_ex.dst;
	assign ex_we  = id_ex.valid && id_ex.reg_write;

	always_ff @(posedge clk) begin
		if (rst) begin
			flags <= '0;
		end else if (id_ex.valid && id_ex.sets_flags) begin
			flags.z <= alu_res == '0;
			flags.n <= alu_res[15];
			flags.v <= alu_v;                       // Zero for logic ops
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ex_mem.valid <= 1'b0;
		end else begin
			ex_mem.valid      <= id_ex.valid;       // Redirecting instr still proceeds
			ex_mem.halt       <= id_ex.halt;
			ex_mem.reg_write  <= id_ex.reg_write;
			ex_mem.mem_read   <= id_ex.mem_read;
			ex_mem.mem_write  <= id_ex.mem_write;
			ex_mem.dst        <= id_ex.dst;
			ex_mem.result     <= result;
			ex_mem.store_data <= id_ex.store_data;
		end
	end

endmodule

`default_nettype wire

// ==== wisc_fetch.sv ====
// Fetch stage with PC, program memory and load port, run control and IF/ID register
`timescale 1ns/1ps
`default_nettype none
`include "wisc_params.svh"

module wisc_fetch (
	input  wire logic                clk,
	input  wire logic                rst,
	input  wire logic                start,        // Begin execution from idle
	input  wire logic                prog_we,
	input  wire wisc_pkg::imem_addr_t prog_addr,
	input  wire wisc_pkg::word_t     prog_data,
	input  wire logic                stall,        // Hold PC and IF/ID
	input  wire logic                redirect,     // Taken control in execute
	input  wire logic                halt_seen,    // HLT decoded, not flushed
	input  wire wisc_pkg::word_t     redirect_pc,
	output wisc_pkg::if_id_t         if_id
);
	import wisc_pkg::*;

	word_t        imem [`WISC_IMEM_DEPTH];          // Program storage
	word_t        pc;                               // Next fetch address
	fetch_state_t state;
	imem_addr_t   fetch_addr;

	assign fetch_addr = pc[`WISC_IMEM_AW-1:0];      // Low PC bits index memory

	// Loader only touches memory while the core is idle
	always_ff @(posedge clk) begin
		if (prog_we && state == FETCH_IDLE) begin
			imem[prog_addr] <= prog_data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= FETCH_IDLE;
		end else if (state == FETCH_IDLE && start) begin
			state <= FETCH_RUN;
		end else if (state == FETCH_RUN && halt_seen) begin
			state <= FETCH_STOPPED;                 // Left only by reset
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc          <= '0;
			if_id.valid <= 1'b0;
		end else if (state != FETCH_RUN) begin
			if_id.valid <= 1'b0;                    // Bubbles when not running
		end else if (redirect) begin
			pc          <= redirect_pc;             // Wins over stall
			if_id.valid <= 1'b0;
		end else if (halt_seen) begin
			if_id.valid <= 1'b0;                    // Nothing after HLT enters
		end else if (!stall) begin
			if_id.valid <= 1'b1;
			if_id.instr <= imem[fetch_addr];
			if_id.pc    <= pc;
			pc          <= pc + 16'd1;
		end
	end

endmodule

`default_nettype wire

// ==== wisc_memory.sv ====
// Memory stage with data memory, store port, writeback select, halted flag and MEM/WB register
`timescale 1ns/1ps
`default_nettype none
`include "wisc_params.svh"

module wisc_memory (
	input  wire logic              clk,
	input  wire logic              rst,
	input  wire wisc_pkg::ex_mem_t ex_mem,
	output wisc_pkg::reg_write_t   wb,           // MEM/WB, also retire
	output wisc_pkg::mem_write_t   store,
	output logic                   halted,
	output wisc_pkg::reg_idx_t     mem_dst,      // For decode hazard test
	output logic                   mem_we
);
	import wisc_pkg::*;

	word_t                   dmem [`WISC_DMEM_DEPTH];
	logic [`WISC_DMEM_AW-1:0] addr;              // Word index
	logic                    halt_wb;            // HLT sitting in MEM/WB

	assign addr    = ex_mem.result[`WISC_DMEM_AW-1:0];
	assign mem_dst = ex_mem.dst;
	assign mem_we  = ex_mem.valid && ex_mem.reg_write;

	assign store = '{strobe: ex_mem.valid && ex_mem.mem_write,
		addr: ex_mem.result, data: ex_mem.store_data};

	always_ff @(posedge clk) begin
		if (store.strobe) begin
			dmem[addr] <= ex_mem.store_data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wb.en   <= 1'b0;
			halt_wb <= 1'b0;
			halted  <= 1'b0;
		end else begin
			wb.en   <= ex_mem.valid && ex_mem.reg_write;
			wb.idx  <= ex_mem.dst;
			wb.data <= ex_mem.mem_read ? dmem[addr] : ex_mem.result; // Load or ALU
			halt_wb <= ex_mem.valid && ex_mem.halt;
			halted  <= halted || halt_wb;           // Sticky until reset
		end
	end

endmodule

`default_nettype wire

// ==== wisc_params.svh ====
// Memory depth and address width macros for the WISC core
`ifndef WISC_PARAMS_SVH
`define WISC_PARAMS_SVH

// Instruction memory
`define WISC_IMEM_DEPTH 256 // Words of program storage
`define WISC_IMEM_AW    8   // Bits of PC used to index it

// Data memory
`define WISC_DMEM_DEPTH 256 // Words of data storage
`define WISC_DMEM_AW    8   // Bits of address used to index it

// Both depths must equal 2**AW so the low address bits
// cover the whole array

`endif

// ==== wisc_pkg.sv ====
// Vector typedefs, opcode/ALU/branch/fetch enums, flag and pipeline register structs
`default_nettype none
`include "wisc_params.svh"

package wisc_pkg;

	typedef logic [15:0] word_t;                     // Data and instruction word
	typedef logic [3:0]  reg_idx_t;                  // Register number
	typedef logic [`WISC_IMEM_AW-1:0] imem_addr_t;   // Program memory index

	typedef enum logic [3:0] {
		OP_ADD, OP_SUB, OP_AND, OP_NOR, OP_XOR, OP_SLL, OP_SRL, OP_SRA,
		OP_LW, OP_SW, OP_LHB, OP_LLB, OP_B, OP_CALL, OP_RET, OP_HLT
	} opcode_t;                                      // Instr[15:12]

	typedef enum logic [2:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_NOR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA
	} alu_op_t;                                      // Same order as first eight opcodes

	typedef enum logic [2:0] {
		BR_NEQ, BR_EQ, BR_GT, BR_LT, BR_GTE, BR_LTE, BR_OVFL, BR_UNCOND
	} br_cond_t;                                     // Instr[11:9] of B

	typedef enum logic [1:0] {
		FETCH_IDLE, FETCH_RUN, FETCH_STOPPED
	} fetch_state_t;                                 // Run control in fetch

	typedef struct packed {
		logic z;                                     // Result zero
		logic n;                                     // Result negative
		logic v;                                     // Signed overflow
	} flags_t;

	typedef struct packed {
		logic  valid;
		word_t instr;
		word_t pc;                                   // Address of instr
	} if_id_t;

	typedef struct packed {
		logic     valid;
		logic     halt;                              // HLT marker
		logic     reg_write;                         // Never set for R0
		logic     mem_read;                          // LW
		logic     mem_write;                         // SW
		logic     alu_src_imm;                       // Operand b from imm
		alu_op_t  alu_op;
		logic     is_branch;
		logic     is_call;
		logic     is_ret;
		br_cond_t br_cond;
		logic     sets_flags;
		word_t    a;                                 // Read port a, R15 on RET
		word_t    b;                                 // Read port b
		word_t    imm;                               // Sign extended or placed
		word_t    store_data;                        // SW data register
		reg_idx_t dst;
		word_t    pc;
	} id_ex_t;

	typedef struct packed {
		logic     valid;
		logic     halt;
		logic     reg_write;
		logic     mem_read;
		logic     mem_write;
		reg_idx_t dst;
		word_t    result;                            // ALU value or address
		word_t    store_data;
	} ex_mem_t;

	typedef struct packed {
		logic     en;
		reg_idx_t idx;
		word_t    data;
	} reg_write_t;                                   // MEM/WB, regfile write, retire

	typedef struct packed {
		logic  strobe;
		word_t addr;
		word_t data;
	} mem_write_t;                                   // Store port

endpackage

`default_nettype wire

// ==== wisc_regfile.sv ====
// Sixteen-entry write-through register file with two read ports and R0 tied to zero
`timescale 1ns/1ps
`default_nettype none

module wisc_regfile (
	input  wire logic                 clk,
	input  wire logic                 rst,
	input  wire wisc_pkg::reg_write_t wr,         // From MEM/WB
	input  wire wisc_pkg::reg_idx_t   ra,
	input  wire wisc_pkg::reg_idx_t   rb,
	output wisc_pkg::word_t           da,
	output wisc_pkg::word_t           db
);
	import wisc_pkg::*;

	word_t regs [16];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= '0;
			end
		end else if (wr.en && wr.idx != '0) begin
			regs[wr.idx] <= wr.data;                // R0 writes dropped
		end
	end

	// Same-cycle write is visible to readers
	assign da = (wr.en && wr.idx == ra && ra != '0) ? wr.data : regs[ra];
	assign db = (wr.en && wr.idx == rb && rb != '0) ? wr.data : regs[rb];

endmodule

`default_nettype wire
